/* filelist.f */
core_array_pkg.sv
core_bus_pkg.sv
stagger_release.sv
accum_core.sv
result_select.sv
core_ctrl_regs.sv
multicore_top.sv
multicore_tb.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f filelist.f --top-module multicore_top
	verilator --lint-only --timing --timescale 1ns/100ps -f filelist.f --top-module multicore_tb

sim:
	verilator --binary --timing --timescale 1ns/100ps -f filelist.f \
		--top-module multicore_tb -Mdir obj_dir
	./obj_dir/Vmulticore_tb | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* multicore_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module multicore_tb
	import core_array_pkg::*;
	import core_bus_pkg::*;
();

	localparam int N_ROWS = 5;
	localparam int TIMEOUT = N_ROWS * 400;

	typedef struct packed {
		logic [STAGGER_W-1:0] interval;
		logic [TAPS-1:0][DATA_W-1:0] samples;
		logic [N_CORES-1:0][DATA_W-1:0] expected;
	} row_t;

	logic clk;
	logic rst;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	sample_t sample_in;
	result_t result_out;

	row_t table_rows [N_ROWS];
	integer seed = 32'he022;
	int errors = 0;
	int cycles = 0;

	multicore_top dut_i (
		.clk(clk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.sample_in(sample_in),
		.result_out(result_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout, the run was still going after %0d cycles", cycles);
			$display("errors: %0d", errors);
			$display("Regression failed");
			$finish;
		end
	end

	// ==================================================
	// helpers
	// ==================================================
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	// each core sums its taps at 31 bits and scales by its index plus one
	function automatic logic [DATA_W-1:0] weighted_sum(
			input logic [TAPS-1:0][DATA_W-1:0] s, input int id);
		logic [DATA_W-1:0] sum;
		sum = '0;
		for (int k = 0; k < TAPS; k++) begin
			sum = sum + s[k];
		end
		return DATA_W'(sum * DATA_W'(id + 1));
	endfunction

	task automatic fill_table();
		logic [31:0] rnd;
		table_rows[0].interval = 8'd0;
		table_rows[0].samples = {31'd4, 31'd3, 31'd2, 31'd1};
		// these two rows push the sum past the signed 31-bit range
		table_rows[1].interval = 8'd2;
		table_rows[1].samples = {4{31'h3fff_ffff}};
		table_rows[2].interval = 8'd5;
		table_rows[2].samples = {31'd1, 31'h4000_0000, 31'h7fff_ffff, 31'h4000_0000};
		for (int r = 3; r < N_ROWS; r++) begin
			rnd = $random(seed);
			table_rows[r].interval = {4'd0, rnd[3:0]};
			for (int k = 0; k < TAPS; k++) begin
				rnd = $random(seed);
				table_rows[r].samples[k] = rnd[DATA_W-1:0];
			end
		end
		for (int r = 0; r < N_ROWS; r++) begin
			for (int id = 0; id < N_CORES; id++) begin
				table_rows[r].expected[id] = weighted_sum(table_rows[r].samples, id);
			end
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		wb_req <= '0;
		sample_in <= '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	endtask

	// one wishbone classic cycle, request held until ack is seen
	task automatic wb_xfer(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		int waits;
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: 4'hf};
		waits = 0;
		do begin
			@(negedge clk);
			waits++;
		end while (!wb_rsp.ack && waits < 8);
		if (!wb_rsp.ack) begin
			errors++;
			$display("bus cycle to address %0d got no ack", adr);
		end
		rdat = wb_rsp.dat;
		@(posedge clk);
		wb_req <= '0;
	endtask

	task automatic wait_result(output logic [31:0] status);
		int polls;
		polls = 0;
		do begin
			wb_xfer(1'b0, ADR_STATUS, 32'd0, status);
			polls++;
		end while (!status[8] && polls < 10);
		if (!status[8]) begin
			errors++;
			$display("no result became ready after %0d status reads", polls);
		end
	endtask

	// ==================================================
	// one table row from reset to the last result
	// ==================================================
	task automatic run_row(input int r);
		row_t row;
		logic [31:0] rd;
		logic [7:0] mask;
		logic [7:0] prev;
		int t0;
		int limit;
		row = table_rows[r];
		limit = N_CORES * (int'(row.interval) + 2);
		apply_reset();
		wb_xfer(1'b0, ADR_STATUS, 32'd0, rd);
		check_value("status after reset", rd, 32'd0);
		wb_xfer(1'b0, ADR_RESULT, 32'd0, rd);
		check_value("result.valid after reset", 32'(rd[31]), 32'd0);
		wb_xfer(1'b1, ADR_CTRL, {23'd0, 1'b1, row.interval}, rd);
		t0 = cycles;
		prev = '0;
		// cores come up from index 0 upward, never leaving a gap
		do begin
			wb_xfer(1'b0, ADR_STATUS, 32'd0, rd);
			mask = rd[7:0];
			check_value("status.running order",
				32'((mask & (mask + 8'd1)) == 8'd0 && mask >= prev), 32'd1);
			check_value("status upper bits", {8'd0, rd[31:8]}, 32'd0);
			prev = mask;
		end while (mask != 8'hff && cycles - t0 <= limit);
		if (mask != 8'hff) begin
			errors++;
			$display("row %0d: cores not all running %0d cycles after start", r, limit);
		end
		for (int k = 0; k < TAPS; k++) begin
			@(posedge clk);
			sample_in <= '{valid: 1'b0, data: DATA_W'($random(seed))};
			@(posedge clk);
			sample_in <= '{valid: 1'b1, data: row.samples[k]};
		end
		@(posedge clk);
		sample_in <= '{valid: 1'b0, data: '0};
		// results sit unread for a while and must still all arrive
		repeat (20) @(posedge clk);
		for (int id = 0; id < N_CORES; id++) begin
			wait_result(rd);
			check_value("status while full", rd, 32'h0000_01ff);
			check_value("result_out.id", 32'(result_out.id), 32'(id));
			check_value("result_out.value", {1'b0, result_out.value}, {1'b0, row.expected[id]});
			wb_xfer(1'b0, ADR_RESULT, 32'd0, rd);
			check_value("result word", rd, {1'b1, 3'(id), row.expected[id][27:0]});
		end
		wb_xfer(1'b0, ADR_RESULT, 32'd0, rd);
		check_value("result.valid after drain", 32'(rd[31]), 32'd0);
		wb_xfer(1'b0, ADR_STATUS, 32'd0, rd);
		check_value("status after drain", rd, 32'h0000_00ff);
	endtask

	initial begin
		rst = 1'b1;
		wb_req = '0;
		sample_in = '0;
		fill_table();
		for (int r = 0; r < N_ROWS; r++) begin
			run_row(r);
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* multicore_top.sv */
`timescale 1ns/100ps
`default_nettype none

module multicore_top
	import core_array_pkg::*;
	import core_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	input sample_t sample_in,
	output result_t result_out
);

	logic [STAGGER_W-1:0] stagger_interval;
	logic start;
	logic [N_CORES-1:0] core_hold;
	logic [N_CORES-1:0] running;
	logic [N_CORES-1:0] offer_ready;
	logic [N_CORES-1:0] grant;
	result_t offers [N_CORES];
	result_t taken;
	logic taken_valid;
	logic room;

	assign running = ~core_hold;

	core_ctrl_regs u_regs (
		.clk(clk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.stagger_interval(stagger_interval),
		.start(start),
		.running(running),
		.taken(taken),
		.taken_valid(taken_valid),
		.room(room),
		.result_out(result_out)
	);

	stagger_release u_release (
		.clk(clk),
		.rst(rst),
		.start(start),
		.stagger_interval(stagger_interval),
		.core_hold(core_hold)
	);

	// ==================================================
	// core array, all fed from the same sample stream
	// ==================================================
	for (genvar i = 0; i < N_CORES; i++) begin : g_core
		accum_core #(
			.CORE_ID(i)
		) u_core (
			.clk(clk),
			.rst(rst),
			.hold(core_hold[i]),
			.sample_in(sample_in),
			.grant(grant[i]),
			.offer(offers[i]),
			.offer_ready(offer_ready[i])
		);
	end

	result_select u_select (
		.clk(clk),
		.rst(rst),
		.offers(offers),
		.offer_ready(offer_ready),
		.room(room),
		.grant(grant),
		.taken(taken),
		.taken_valid(taken_valid)
	);

endmodule

`default_nettype wire

/* core_ctrl_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module core_ctrl_regs
	import core_array_pkg::*;
	import core_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output logic [STAGGER_W-1:0] stagger_interval,
	output logic start,
	input logic [N_CORES-1:0] running,
	input result_t taken,
	input logic taken_valid,
	output logic room,
	output result_t result_out
);

	logic ack;
	logic [31:0] rdata;
	logic req_go;
	logic result_full;
	result_t result_reg;

	// a request is acted on once, in the cycle that raises ack
	assign req_go = wb_req.cyc && wb_req.stb && !ack;

	// ==================================================
	// bus handshake and control writes
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			start <= 1'b0;
			stagger_interval <= '0;
		end else begin
			ack <= req_go;
			start <= 1'b0;
			if (req_go && wb_req.we && wb_req.adr == ADR_CTRL) begin
				if (wb_req.sel[0]) begin
					stagger_interval <= wb_req.dat[STAGGER_W-1:0];
				end
				if (wb_req.sel[1] && wb_req.dat[8]) begin
					start <= 1'b1;
				end
			end
		end
	end

	// read data is sampled together with ack
	always_ff @(posedge clk) begin
		if (req_go && !wb_req.we) begin
			case (wb_req.adr)
				ADR_CTRL: rdata <= {{(32 - STAGGER_W){1'b0}}, stagger_interval};
				ADR_STATUS: rdata <= {{(31 - N_CORES){1'b0}}, result_full, running};
				ADR_RESULT: rdata <= {result_full, result_reg.id, result_reg.value[27:0]};
				default: rdata <= '0;
			endcase
		end
	end

	// ==================================================
	// result holding register
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			result_full <= 1'b0;
		end else begin
			if (req_go && !wb_req.we && wb_req.adr == ADR_RESULT && result_full) begin
				result_full <= 1'b0;
			end
			// the selector only hands over when room was high
			if (taken_valid) begin
				result_full <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (taken_valid) begin
			result_reg <= taken;
		end
	end

	assign room = !result_full;
	assign result_out = result_reg;
	assign wb_rsp = '{ack: ack, dat: rdata};

endmodule

`default_nettype wire

/* result_select.sv */
`timescale 1ns/100ps
`default_nettype none

module result_select
	import core_array_pkg::*;
(
	input logic clk,
	input logic rst,
	input result_t offers [N_CORES],
	input logic [N_CORES-1:0] offer_ready,
	input logic room,
	output logic [N_CORES-1:0] grant,
	output result_t taken,
	output logic taken_valid
);

	logic [ID_W-1:0] pick;
	logic pick_valid;
	logic issue;

	// lowest index wins, so scan from the top and let lower hits overwrite
	always_comb begin
		pick = '0;
		pick_valid = 1'b0;
		for (int i = N_CORES - 1; i >= 0; i--) begin
			if (offer_ready[i]) begin
				pick = ID_W'(i);
				pick_valid = 1'b1;
			end
		end
	end

	// while a transfer is in flight the granted core still shows ready
	// and room has not yet dropped, so hold off for that cycle
	assign issue = room && !taken_valid && pick_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= '0;
			taken_valid <= 1'b0;
		end else begin
			grant <= '0;
			taken_valid <= issue;
			if (issue) begin
				grant[pick] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			taken <= offers[pick];
		end
	end

endmodule

`default_nettype wire

/* accum_core.sv */
`timescale 1ns/100ps
`default_nettype none

module accum_core
	import core_array_pkg::*;
#(
	parameter int CORE_ID = 0
) (
	input logic clk,
	input logic rst,
	input logic hold,
	input sample_t sample_in,
	input logic grant,
	output result_t offer,
	output logic offer_ready
);

	localparam int TAP_W = $clog2(TAPS);
	localparam logic signed [DATA_W-1:0] WEIGHT = DATA_W'(CORE_ID + 1);

	logic [TAP_W-1:0] taps;
	logic signed [DATA_W-1:0] acc;
	logic signed [DATA_W-1:0] sum_next;
	logic signed [DATA_W-1:0] product;

	// the sum wraps at DATA_W bits, as does the weighted product
	assign sum_next = acc + sample_in.data;

	always_ff @(posedge clk) begin
		if (rst || hold) begin
			acc <= '0;
			taps <= '0;
			offer_ready <= 1'b0;
		end else if (offer_ready) begin
			// samples arriving now are not ours, wait for the selector
			if (grant) begin
				offer_ready <= 1'b0;
				acc <= '0;
			end
		end else if (sample_in.valid) begin
			acc <= sum_next;
			if (taps == TAP_W'(TAPS - 1)) begin
				taps <= '0;
				offer_ready <= 1'b1;
			end else begin
				taps <= taps + 1'b1;
			end
		end
	end

	// product is captured with the last tap and held while offering
	always_ff @(posedge clk) begin
		if (!offer_ready && sample_in.valid && taps == TAP_W'(TAPS - 1)) begin
			product <= sum_next * WEIGHT;
		end
	end

	assign offer = '{id: ID_W'(CORE_ID), value: product};

endmodule

`default_nettype wire

/* stagger_release.sv */
`timescale 1ns/100ps
`default_nettype none

module stagger_release
	import core_array_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [STAGGER_W-1:0] stagger_interval,
	output logic [N_CORES-1:0] core_hold
);

	logic active;
	logic [STAGGER_W-1:0] cnt;
	logic [ID_W-1:0] ptr;

	// a sequence can only be started from the all-held state
	// so a second start while cores are leaving hold does nothing
	always_ff @(posedge clk) begin
		if (rst) begin
			core_hold <= '1;
			active <= 1'b0;
			cnt <= '0;
			ptr <= '0;
		end else if (!active) begin
			if (start && (&core_hold)) begin
				active <= 1'b1;
				cnt <= '0;
				ptr <= '0;
			end
		end else if (cnt == stagger_interval) begin
			// interval spent, let the next core run
			core_hold[ptr] <= 1'b0;
			cnt <= '0;
			ptr <= ptr + 1'b1;
			if (ptr == ID_W'(N_CORES - 1)) begin
				active <= 1'b0;
			end
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* core_bus_pkg.sv */
`default_nettype none

package core_bus_pkg;

	// ==================================================
	// wishbone classic, master to slave and back
	// ==================================================
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] adr;
		logic [31:0] dat;
		logic [3:0] sel;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// ==================================================
	// register map, word addresses
	// ==================================================
	localparam logic [3:0] ADR_CTRL = 4'd0;
	localparam logic [3:0] ADR_STATUS = 4'd1;
	localparam logic [3:0] ADR_RESULT = 4'd2;

endpackage

`default_nettype wire

/* core_array_pkg.sv */
`default_nettype none

package core_array_pkg;

	// ==================================================
	// array dimensions
	// ==================================================
	localparam int N_CORES = 8;
	localparam int TAPS = 4;
	localparam int DATA_W = 31;
	localparam int ID_W = 3;
	localparam int STAGGER_W = 8;

	// ==================================================
	// stream and result words
	// ==================================================

	// one broadcast sample, seen by every core in the same cycle
	typedef struct packed {
		logic valid;
		logic signed [DATA_W-1:0] data;
	} sample_t;

	// a finished job, tagged with the core that produced it
	typedef struct packed {
		logic [ID_W-1:0] id;
		logic signed [DATA_W-1:0] value;
	} result_t;

endpackage

`default_nettype wire
